//--- dcd_dsptc_top.sv
`timescale 1ns/100ps
`include "dcd_params.svh"

module dcd_dsptc_top (
	input logic clk,
	input logic rst,
	input logic flush_req,
	input logic [63:0] s_if_data, // {pc, instruction}
	input logic s_if_valid,
	output logic s_if_ready,
	output dcd_pkg::alu_msg_t m_alu_msg,
	output logic [4:0] m_alu_rd_id,
	output logic [2:0] m_alu_err_code,
	output logic [31:0] m_alu_pc,
	output logic [`INST_ID_WIDTH-1:0] m_alu_inst_id,
	output logic m_alu_valid,
	input logic m_alu_ready,
	output dcd_pkg::lsu_msg_t m_lsu_msg,
	output logic [4:0] m_lsu_rd_id,
	output logic [`INST_ID_WIDTH-1:0] m_lsu_inst_id,
	output logic m_lsu_valid,
	input logic m_lsu_ready,
	output dcd_pkg::mul_msg_t m_mul_msg,
	output logic [4:0] m_mul_rd_id,
	output logic [`INST_ID_WIDTH-1:0] m_mul_inst_id,
	output logic m_mul_valid,
	input logic m_mul_ready,
	input dcd_pkg::wb_t wb
);

	import dcd_pkg::*;

	logic [4:0] rd_req_rs1_id;
	logic [4:0] rd_req_rs2_id;
	logic rd_req_rs1_vld;
	logic rd_req_rs2_vld;
	logic rd_req_valid;
	logic rd_req_ready;
	logic [31:0] rd_res_rs1_v;
	logic [31:0] rd_res_rs2_v;
	logic rd_res_valid;
	logic rd_res_ready;
	logic p0_req;
	logic [4:0] p0_addr;
	logic p0_grant;
	logic [31:0] p0_dout;
	logic p1_req;
	logic [4:0] p1_addr;
	logic p1_grant;
	logic [31:0] p1_dout;
	logic [4:0] raw_rs1_id;
	logic [4:0] raw_rs2_id;
	logic rs1_raw;
	logic rs2_raw;
	logic [4:0] waw_rd_id;
	logic rd_waw;
	logic set_valid;
	logic [4:0] set_rd;
	dispatch_req_t dsp_req;
	logic dsp_req_valid;
	logic dsp_req_ready;

	dispatch_msg_gen dispatch_msg_gen_u (
		.clk(clk),
		.rst(rst),
		.flush_req(flush_req),
		.s_if_data(s_if_data),
		.s_if_valid(s_if_valid),
		.s_if_ready(s_if_ready),
		.rd_req_rs1_id(rd_req_rs1_id),
		.rd_req_rs2_id(rd_req_rs2_id),
		.rd_req_rs1_vld(rd_req_rs1_vld),
		.rd_req_rs2_vld(rd_req_rs2_vld),
		.rd_req_valid(rd_req_valid),
		.rd_req_ready(rd_req_ready),
		.rd_res_rs1_v(rd_res_rs1_v),
		.rd_res_rs2_v(rd_res_rs2_v),
		.rd_res_valid(rd_res_valid),
		.rd_res_ready(rd_res_ready),
		.m_req(dsp_req),
		.m_req_valid(dsp_req_valid),
		.m_req_ready(dsp_req_ready)
	);

	reg_file_rd reg_file_rd_u (
		.clk(clk),
		.rst(rst),
		.flush_req(flush_req),
		.req_rs1_id(rd_req_rs1_id),
		.req_rs2_id(rd_req_rs2_id),
		.req_rs1_vld(rd_req_rs1_vld),
		.req_rs2_vld(rd_req_rs2_vld),
		.req_valid(rd_req_valid),
		.req_ready(rd_req_ready),
		.res_rs1_v(rd_res_rs1_v),
		.res_rs2_v(rd_res_rs2_v),
		.res_valid(rd_res_valid),
		.res_ready(rd_res_ready),
		.raw_rs1_id(raw_rs1_id),
		.raw_rs2_id(raw_rs2_id),
		.rs1_raw(rs1_raw),
		.rs2_raw(rs2_raw),
		.rd_p0_req(p0_req),
		.rd_p0_addr(p0_addr),
		.rd_p0_grant(p0_grant),
		.rd_p0_dout(p0_dout),
		.rd_p1_req(p1_req),
		.rd_p1_addr(p1_addr),
		.rd_p1_grant(p1_grant),
		.rd_p1_dout(p1_dout)
	);

	reg_file reg_file_u (
		.clk(clk),
		.rst(rst),
		.rd_p0_req(p0_req),
		.rd_p0_addr(p0_addr),
		.rd_p0_grant(p0_grant),
		.rd_p0_dout(p0_dout),
		.rd_p1_req(p1_req),
		.rd_p1_addr(p1_addr),
		.rd_p1_grant(p1_grant),
		.rd_p1_dout(p1_dout),
		.wb(wb)
	);

	dpc_scoreboard dpc_scoreboard_u (
		.clk(clk),
		.rst(rst),
		.rs1_id(raw_rs1_id),
		.rs2_id(raw_rs2_id),
		.rd_id(waw_rd_id),
		.rs1_raw(rs1_raw),
		.rs2_raw(rs2_raw),
		.rd_waw(rd_waw),
		.set_valid(set_valid),
		.set_rd(set_rd),
		.wb(wb)
	);

	dispatcher dispatcher_u (
		.clk(clk),
		.rst(rst),
		.flush_req(flush_req),
		.s_req(dsp_req),
		.s_req_valid(dsp_req_valid),
		.s_req_ready(dsp_req_ready),
		.rd_id(waw_rd_id),
		.rd_waw(rd_waw),
		.set_valid(set_valid),
		.set_rd(set_rd),
		.m_alu_msg(m_alu_msg),
		.m_alu_rd_id(m_alu_rd_id),
		.m_alu_err_code(m_alu_err_code),
		.m_alu_pc(m_alu_pc),
		.m_alu_inst_id(m_alu_inst_id),
		.m_alu_valid(m_alu_valid),
		.m_alu_ready(m_alu_ready),
		.m_lsu_msg(m_lsu_msg),
		.m_lsu_rd_id(m_lsu_rd_id),
		.m_lsu_inst_id(m_lsu_inst_id),
		.m_lsu_valid(m_lsu_valid),
		.m_lsu_ready(m_lsu_ready),
		.m_mul_msg(m_mul_msg),
		.m_mul_rd_id(m_mul_rd_id),
		.m_mul_inst_id(m_mul_inst_id),
		.m_mul_valid(m_mul_valid),
		.m_mul_ready(m_mul_ready)
	);

endmodule

//--- dcd_params.svh
`ifndef DCD_PARAMS_SVH
`define DCD_PARAMS_SVH

`define INST_ID_WIDTH 4 // instruction number, wraps modulo 16
`define REG_NUM 32 // architectural registers

`define OPC_OP 7'b0110011 // register-register, also MUL/MULH
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111
`define OPC_LOAD 7'b0000011
`define OPC_STORE 7'b0100011

`define ERR_NONE 3'b000 // normal instruction
`define ERR_ILLEGAL 3'b001 // illegal instruction word

`endif

//--- dcd_pkg.sv
`include "dcd_params.svh"

package dcd_pkg;

	typedef enum logic [1:0] {
		UNIT_ALU = 2'd0,
		UNIT_LSU = 2'd1,
		UNIT_MUL = 2'd2
	} unit_sel_e;

	typedef struct packed {
		logic [3:0] op_mode; // {alt, funct3}
		logic [31:0] op1;
		logic [31:0] op2; // instruction word when illegal
	} alu_msg_t;

	typedef struct packed {
		logic ls_sel; // 0 load, 1 store
		logic [2:0] ls_type; // funct3
		logic [31:0] addr; // base plus offset
		logic [31:0] st_data;
	} lsu_msg_t;

	typedef struct packed {
		logic [32:0] op_a; // extended rs1
		logic [32:0] op_b; // extended rs2
		logic res_hi; // take upper 32 bits
		logic pad;
	} mul_msg_t;

	// one 68-bit word, read in the view picked by the unit selector
	typedef union packed {
		alu_msg_t alu;
		lsu_msg_t lsu;
		mul_msg_t mul;
	} dispatch_msg_u;

	typedef struct packed {
		unit_sel_e unit;
		dispatch_msg_u msg;
		logic [4:0] rd_id; // zero when rd_vld is low
		logic rd_vld;
		logic [2:0] err_code;
		logic [31:0] pc;
		logic [`INST_ID_WIDTH-1:0] inst_id;
	} dispatch_req_t;

	typedef struct packed {
		logic valid;
		logic [4:0] rd;
		logic [31:0] data;
	} wb_t;

endpackage

//--- dcd_trace.txt
// preload: 0 reg value 0 0 0 0 / instruction: 1 inst pc ctrl a b wb_data / end: f
// ctrl: [1:0] unit, [7:4] mode, [8] ext a, [9] ext b, [14:12] err, [20:16] rd
0 00000001 00000010 0 0 0 0
0 00000002 00000003 0 0 0 0
0 00000003 fffffff0 0 0 0 0
0 00000004 80000000 0 0 0 0
0 00000005 12345678 0 0 0 0
1 00208333 00000100 00060000 00000010 00000003 00000013
1 401303b3 00000104 00070080 00000013 00000010 00000003
1 ffb18413 00000108 00080000 fffffff0 fffffffb ffffffeb
1 40425493 0000010c 000900d0 80000000 00000004 f8000000
1 abcde537 00000110 000a0000 00000000 abcde000 abcde000
1 0080a583 00000114 000b0021 00000018 00000000 cafe0001
1 fe51ae23 00000118 000000a1 ffffffec 12345678 00000000
1 00058603 0000011c 000c0001 cafe0001 00000000 00000055
1 023106b3 00000120 000d0202 00000003 fffffff0 ffffffd0
1 02321733 00000124 000e0312 80000000 fffffff0 00000008
1 023237b3 00000128 000f0012 80000000 fffffff0 7ffffff8
1 02322833 0000012c 00100112 80000000 fffffff0 80000008
1 0220c8b3 00000130 00001000 00000000 0220c8b3 00000000
1 ffffffff 00000134 00001000 00000000 ffffffff 00000000
1 0093e333 00000138 00060060 00000003 f8000000 f8000003
1 7ff14313 0000013c 00060040 00000003 000007ff 000007fc
1 00a33933 00000140 00120030 000007fc abcde000 00000001
1 01f91993 00000144 00130010 00000001 0000001f 80000000
1 01351123 00000148 00000091 abcde002 80000000 00000000
1 0000006f 0000014c 00001000 00000000 0000006f 00000000
f 0 0 0 0 0 0

//--- dispatch_msg_gen.sv
`timescale 1ns/100ps
`include "dcd_params.svh"

module dispatch_msg_gen (
	input logic clk,
	input logic rst,
	input logic flush_req,
	input logic [63:0] s_if_data, // {pc, instruction}
	input logic s_if_valid,
	output logic s_if_ready,
	output logic [4:0] rd_req_rs1_id,
	output logic [4:0] rd_req_rs2_id,
	output logic rd_req_rs1_vld,
	output logic rd_req_rs2_vld,
	output logic rd_req_valid,
	input logic rd_req_ready,
	input logic [31:0] rd_res_rs1_v,
	input logic [31:0] rd_res_rs2_v,
	input logic rd_res_valid,
	output logic rd_res_ready,
	output dcd_pkg::dispatch_req_t m_req,
	output logic m_req_valid,
	input logic m_req_ready
);

	import dcd_pkg::*;

	logic dec_valid;
	logic dec_valid_nxt;
	logic if_ready_r;
	logic if_fire;
	logic rd_req_fire;
	logic [31:0] inst1;
	logic [31:0] pc1;
	logic [31:0] inst2;
	logic [31:0] pc2;
	logic [`INST_ID_WIDTH-1:0] inst_cnt;
	logic [`INST_ID_WIDTH-1:0] id1;
	logic [`INST_ID_WIDTH-1:0] id2;
	logic [6:0] opc1;
	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	logic [4:0] rd;
	logic is_op;
	logic is_mul;
	logic is_opimm;
	logic is_lui;
	logic is_load;
	logic is_store;
	logic legal;
	logic wr_rd;
	logic shift_imm;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_u;
	alu_msg_t alu_v;
	lsu_msg_t lsu_v;
	mul_msg_t mul_v;
	dispatch_msg_u msg;
	unit_sel_e unit;

	assign if_fire = s_if_valid && s_if_ready;
	assign rd_req_fire = rd_req_valid && rd_req_ready;
	assign dec_valid_nxt = !flush_req && (if_fire || (dec_valid && !rd_req_fire));
	assign s_if_ready = if_ready_r; // registered, low while in reset

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
			if_ready_r <= 1'b0;
			inst_cnt <= '0;
		end else begin
			dec_valid <= dec_valid_nxt;
			if_ready_r <= !dec_valid_nxt;
			if (if_fire) inst_cnt <= inst_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (if_fire) begin
			pc1 <= s_if_data[63:32];
			inst1 <= s_if_data[31:0];
			id1 <= inst_cnt;
		end
		if (rd_req_fire) begin // moves alongside the read result
			inst2 <= inst1;
			pc2 <= pc1;
			id2 <= id1;
		end
	end

	assign opc1 = inst1[6:0];
	assign rd_req_valid = dec_valid;
	assign rd_req_rs1_id = inst1[19:15];
	assign rd_req_rs2_id = inst1[24:20];
	assign rd_req_rs1_vld = opc1 == `OPC_OP || opc1 == `OPC_OP_IMM ||
		opc1 == `OPC_LOAD || opc1 == `OPC_STORE;
	assign rd_req_rs2_vld = opc1 == `OPC_OP || opc1 == `OPC_STORE;

	assign opc = inst2[6:0];
	assign f3 = inst2[14:12];
	assign f7 = inst2[31:25];
	assign rd = inst2[11:7];
	assign shift_imm = f3 == 3'd1 || f3 == 3'd5;

	assign is_op = opc == `OPC_OP && (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
	assign is_mul = opc == `OPC_OP && f7 == 7'h01 && !f3[2]; // no division
	assign is_opimm = opc == `OPC_OP_IMM &&
		(!shift_imm || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20));
	assign is_lui = opc == `OPC_LUI;
	assign is_load = opc == `OPC_LOAD && f3 != 3'd3 && f3 != 3'd6 && f3 != 3'd7;
	assign is_store = opc == `OPC_STORE && f3 <= 3'd2;
	assign legal = is_op || is_mul || is_opimm || is_lui || is_load || is_store;
	assign wr_rd = legal && !is_store && rd != 5'd0; // x0 never goes pending

	assign imm_i = {{20{inst2[31]}}, inst2[31:20]};
	assign imm_s = {{20{inst2[31]}}, inst2[31:25], inst2[11:7]};
	assign imm_u = {inst2[31:12], 12'd0};

	always_comb begin
		alu_v.op_mode = 4'd0;
		alu_v.op1 = rd_res_rs1_v; // zero for lui, rs1 is not read
		alu_v.op2 = imm_i;
		if (!legal) begin
			alu_v.op1 = 32'd0;
			alu_v.op2 = inst2;
		end else if (is_lui) begin
			alu_v.op2 = imm_u;
		end else if (is_op) begin
			alu_v.op_mode = {inst2[30], f3}; // sub/sra
			alu_v.op2 = rd_res_rs2_v;
		end else begin
			alu_v.op_mode = {shift_imm & inst2[30], f3};
			if (shift_imm) alu_v.op2 = {27'd0, inst2[24:20]}; // shamt only
		end
	end

	assign lsu_v.ls_sel = is_store;
	assign lsu_v.ls_type = f3;
	assign lsu_v.addr = rd_res_rs1_v + (is_store ? imm_s : imm_i);
	assign lsu_v.st_data = rd_res_rs2_v; // zero for loads

	// mulhu zero extends both, mulhsu only op b
	assign mul_v.op_a = {(f3 != 3'd3) && rd_res_rs1_v[31], rd_res_rs1_v};
	assign mul_v.op_b = {!f3[1] && rd_res_rs2_v[31], rd_res_rs2_v};
	assign mul_v.res_hi = f3 != 3'd0;
	assign mul_v.pad = 1'b0;

	always_comb begin
		msg = '0;
		if (is_mul) begin
			unit = UNIT_MUL;
			msg.mul = mul_v;
		end else if (is_load || is_store) begin
			unit = UNIT_LSU;
			msg.lsu = lsu_v;
		end else begin
			unit = UNIT_ALU; // illegal words land here too
			msg.alu = alu_v;
		end
	end

	assign m_req.unit = unit;
	assign m_req.msg = msg;
	assign m_req.rd_id = wr_rd ? rd : 5'd0;
	assign m_req.rd_vld = wr_rd;
	assign m_req.err_code = legal ? `ERR_NONE : `ERR_ILLEGAL;
	assign m_req.pc = pc2;
	assign m_req.inst_id = id2;
	assign m_req_valid = rd_res_valid;
	assign rd_res_ready = m_req_ready;

endmodule

//--- dispatcher.sv
`timescale 1ns/100ps
`include "dcd_params.svh"

module dispatcher (
	input logic clk,
	input logic rst,
	input logic flush_req,
	input dcd_pkg::dispatch_req_t s_req,
	input logic s_req_valid,
	output logic s_req_ready,
	output logic [4:0] rd_id,
	input logic rd_waw,
	output logic set_valid,
	output logic [4:0] set_rd,
	output dcd_pkg::alu_msg_t m_alu_msg,
	output logic [4:0] m_alu_rd_id,
	output logic [2:0] m_alu_err_code,
	output logic [31:0] m_alu_pc,
	output logic [`INST_ID_WIDTH-1:0] m_alu_inst_id,
	output logic m_alu_valid,
	input logic m_alu_ready,
	output dcd_pkg::lsu_msg_t m_lsu_msg,
	output logic [4:0] m_lsu_rd_id,
	output logic [`INST_ID_WIDTH-1:0] m_lsu_inst_id,
	output logic m_lsu_valid,
	input logic m_lsu_ready,
	output dcd_pkg::mul_msg_t m_mul_msg,
	output logic [4:0] m_mul_rd_id,
	output logic [`INST_ID_WIDTH-1:0] m_mul_inst_id,
	output logic m_mul_valid,
	input logic m_mul_ready
);

	import dcd_pkg::*;

	logic vld;
	dispatch_req_t req_r;
	logic out_ready;
	logic out_fire;
	logic s_fire;
	logic waw_block;

	assign rd_id = s_req.rd_id;
	assign waw_block = s_req.rd_vld && rd_waw; // older write to rd still outstanding

	always_comb begin
		case (req_r.unit)
			UNIT_LSU: out_ready = m_lsu_ready;
			UNIT_MUL: out_ready = m_mul_ready;
			default: out_ready = m_alu_ready;
		endcase
	end

	assign out_fire = vld && out_ready;
	// nothing taken during flush, so no pending bit is set for a dropped instruction
	assign s_req_ready = !flush_req && (!vld || out_ready) && !waw_block;
	assign s_fire = s_req_valid && s_req_ready;
	assign set_valid = s_fire && s_req.rd_vld;
	assign set_rd = s_req.rd_id;

	always_ff @(posedge clk) begin
		if (rst) begin
			vld <= 1'b0;
		end else if (flush_req) begin
			vld <= 1'b0;
		end else if (s_fire) begin
			vld <= 1'b1;
		end else if (out_fire) begin
			vld <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (s_fire) req_r <= s_req;
	end

	assign m_alu_valid = vld && req_r.unit == UNIT_ALU;
	assign m_lsu_valid = vld && req_r.unit == UNIT_LSU;
	assign m_mul_valid = vld && req_r.unit == UNIT_MUL;

	assign m_alu_msg = req_r.msg.alu;
	assign m_alu_rd_id = req_r.rd_id;
	assign m_alu_err_code = req_r.err_code;
	assign m_alu_pc = req_r.pc;
	assign m_alu_inst_id = req_r.inst_id;

	assign m_lsu_msg = req_r.msg.lsu;
	assign m_lsu_rd_id = req_r.rd_id; // zero for stores
	assign m_lsu_inst_id = req_r.inst_id;

	assign m_mul_msg = req_r.msg.mul;
	assign m_mul_rd_id = req_r.rd_id;
	assign m_mul_inst_id = req_r.inst_id;

endmodule

//--- dpc_scoreboard.sv
`timescale 1ns/100ps
`include "dcd_params.svh"

module dpc_scoreboard (
	input logic clk,
	input logic rst,
	input logic [4:0] rs1_id,
	input logic [4:0] rs2_id,
	input logic [4:0] rd_id,
	output logic rs1_raw,
	output logic rs2_raw,
	output logic rd_waw,
	input logic set_valid,
	input logic [4:0] set_rd,
	input dcd_pkg::wb_t wb
);

	logic [`REG_NUM-1:0] pending; // one bit per register awaiting writeback
	logic [`REG_NUM-1:0] set_mask;
	logic [`REG_NUM-1:0] clr_mask;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (set_valid) set_mask[set_rd] = 1'b1;
		if (wb.valid) clr_mask[wb.rd] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clr_mask) | set_mask; // set wins over clear
		end
	end

	assign rs1_raw = pending[rs1_id];
	assign rs2_raw = pending[rs2_id];
	assign rd_waw = pending[rd_id];

	// register preload happens while nothing is pending
	a_wb_pending: assert property (@(posedge clk) disable iff (rst)
		(wb.valid && |pending) |-> pending[wb.rd]);

endmodule

//--- reg_file.sv
`timescale 1ns/100ps
`include "dcd_params.svh"

module reg_file (
	input logic clk,
	input logic rst,
	input logic rd_p0_req,
	input logic [4:0] rd_p0_addr,
	output logic rd_p0_grant,
	output logic [31:0] rd_p0_dout,
	input logic rd_p1_req,
	input logic [4:0] rd_p1_addr,
	output logic rd_p1_grant,
	output logic [31:0] rd_p1_dout,
	input dcd_pkg::wb_t wb
);

	logic [31:0] regs [1:`REG_NUM-1]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (wb.valid && wb.rd != 5'd0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	assign rd_p0_dout = (rd_p0_addr == 5'd0) ? 32'd0 : regs[rd_p0_addr];
	assign rd_p1_dout = (rd_p1_addr == 5'd0) ? 32'd0 : regs[rd_p1_addr];

	// no grant while the same register is being written this cycle
	assign rd_p0_grant = rd_p0_req && !(wb.valid && wb.rd == rd_p0_addr);
	assign rd_p1_grant = rd_p1_req && !(wb.valid && wb.rd == rd_p1_addr);

	// writeback only comes for instructions that really write a register
	a_wb_not_x0: assert property (@(posedge clk) disable iff (rst)
		wb.valid |-> wb.rd != 5'd0);

endmodule

//--- reg_file_rd.sv
`timescale 1ns/100ps

module reg_file_rd (
	input logic clk,
	input logic rst,
	input logic flush_req,
	input logic [4:0] req_rs1_id,
	input logic [4:0] req_rs2_id,
	input logic req_rs1_vld,
	input logic req_rs2_vld,
	input logic req_valid,
	output logic req_ready,
	output logic [31:0] res_rs1_v,
	output logic [31:0] res_rs2_v,
	output logic res_valid,
	input logic res_ready,
	output logic [4:0] raw_rs1_id,
	output logic [4:0] raw_rs2_id,
	input logic rs1_raw,
	input logic rs2_raw,
	output logic rd_p0_req,
	output logic [4:0] rd_p0_addr,
	input logic rd_p0_grant,
	input logic [31:0] rd_p0_dout,
	output logic rd_p1_req,
	output logic [4:0] rd_p1_addr,
	input logic rd_p1_grant,
	input logic [31:0] rd_p1_dout
);

	logic no_raw;
	logic grant_ok;
	logic rd_fire;

	assign raw_rs1_id = req_rs1_id;
	assign raw_rs2_id = req_rs2_id;
	assign no_raw = !(req_rs1_vld && rs1_raw) && !(req_rs2_vld && rs2_raw);

	// reads start only into an empty result slot, so an older instruction
	// has reached the dispatcher and marked its rd before the next read
	assign rd_p0_req = req_valid && req_rs1_vld && no_raw && !res_valid;
	assign rd_p1_req = req_valid && req_rs2_vld && no_raw && !res_valid;
	assign rd_p0_addr = req_rs1_id;
	assign rd_p1_addr = req_rs2_id;

	assign grant_ok = (!req_rs1_vld || rd_p0_grant) && (!req_rs2_vld || rd_p1_grant);
	assign req_ready = no_raw && !res_valid && grant_ok;
	assign rd_fire = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else if (flush_req) begin
			res_valid <= 1'b0;
		end else if (rd_fire) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			res_rs1_v <= req_rs1_vld ? rd_p0_dout : 32'd0; // unused source reads zero
			res_rs2_v <= req_rs2_vld ? rd_p1_dout : 32'd0;
		end
	end

	// decode register keeps its request until the read is taken
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		(req_valid && !req_ready && !flush_req) |=>
		(req_valid && $stable(req_rs1_id) && $stable(req_rs2_id)));

endmodule

//--- src.f
+incdir+.
dcd_pkg.sv
reg_file.sv
dpc_scoreboard.sv
reg_file_rd.sv
dispatch_msg_gen.sv
dispatcher.sv
dcd_dsptc_top.sv
tb_dcd_dsptc.sv

//--- tb_dcd_dsptc.sv
`timescale 1ns/100ps
`include "dcd_params.svh"

module tb_dcd_dsptc;

	import dcd_pkg::*;

	localparam int REC_WORDS = 7; // words per trace record
	localparam int MAX_WORDS = 512;

	logic clk;
	logic rst;
	logic flush_req;
	logic [63:0] s_if_data;
	logic s_if_valid;
	logic s_if_ready;
	alu_msg_t m_alu_msg;
	logic [4:0] m_alu_rd_id;
	logic [2:0] m_alu_err_code;
	logic [31:0] m_alu_pc;
	logic [`INST_ID_WIDTH-1:0] m_alu_inst_id;
	logic m_alu_valid;
	logic m_alu_ready;
	lsu_msg_t m_lsu_msg;
	logic [4:0] m_lsu_rd_id;
	logic [`INST_ID_WIDTH-1:0] m_lsu_inst_id;
	logic m_lsu_valid;
	logic m_lsu_ready;
	mul_msg_t m_mul_msg;
	logic [4:0] m_mul_rd_id;
	logic [`INST_ID_WIDTH-1:0] m_mul_inst_id;
	logic m_mul_valid;
	logic m_mul_ready;
	wb_t wb;

	logic [31:0] trace_mem [0:MAX_WORDS-1];
	int n_pre;
	int n_inst;
	int seed;
	logic trace_loaded;

	dcd_dsptc_top UUT (
		.clk(clk),
		.rst(rst),
		.flush_req(flush_req),
		.s_if_data(s_if_data),
		.s_if_valid(s_if_valid),
		.s_if_ready(s_if_ready),
		.m_alu_msg(m_alu_msg),
		.m_alu_rd_id(m_alu_rd_id),
		.m_alu_err_code(m_alu_err_code),
		.m_alu_pc(m_alu_pc),
		.m_alu_inst_id(m_alu_inst_id),
		.m_alu_valid(m_alu_valid),
		.m_alu_ready(m_alu_ready),
		.m_lsu_msg(m_lsu_msg),
		.m_lsu_rd_id(m_lsu_rd_id),
		.m_lsu_inst_id(m_lsu_inst_id),
		.m_lsu_valid(m_lsu_valid),
		.m_lsu_ready(m_lsu_ready),
		.m_mul_msg(m_mul_msg),
		.m_mul_rd_id(m_mul_rd_id),
		.m_mul_inst_id(m_mul_inst_id),
		.m_mul_valid(m_mul_valid),
		.m_mul_ready(m_mul_ready),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	function automatic logic [31:0] rec_word(input int rec, input int w);
		return trace_mem[rec * REC_WORDS + w];
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	// compares the port that takes the instruction now with its trace record
	task automatic check_dispatch(input int rec, input int num);
		logic [31:0] pc;
		logic [31:0] ctrl;
		logic [31:0] exp_a;
		logic [31:0] exp_b;
		logic [`INST_ID_WIDTH-1:0] exp_id;
		logic [1:0] act_unit;
		string tag;
		pc = rec_word(rec, 2);
		ctrl = rec_word(rec, 3);
		exp_a = rec_word(rec, 4);
		exp_b = rec_word(rec, 5);
		exp_id = num[`INST_ID_WIDTH-1:0]; // ids wrap modulo 16
		tag = $sformatf("inst %0d pc %h", num, pc);
		act_unit = m_mul_valid ? 2'd2 : (m_lsu_valid ? 2'd1 : 2'd0);
		check_val({tag, " unit"}, ctrl[1:0], act_unit);
		case (act_unit)
			2'd0: begin
				check_val({tag, " op_mode"}, ctrl[7:4], m_alu_msg.op_mode);
				check_val({tag, " op1"}, exp_a, m_alu_msg.op1);
				check_val({tag, " op2"}, exp_b, m_alu_msg.op2);
				check_val({tag, " err"}, ctrl[14:12], m_alu_err_code);
				check_val({tag, " rd"}, ctrl[20:16], m_alu_rd_id);
				check_val({tag, " pc"}, pc, m_alu_pc);
				check_val({tag, " id"}, exp_id, m_alu_inst_id);
			end
			2'd1: begin
				check_val({tag, " ls_sel/type"}, ctrl[7:4],
					{m_lsu_msg.ls_sel, m_lsu_msg.ls_type});
				check_val({tag, " addr"}, exp_a, m_lsu_msg.addr);
				check_val({tag, " st_data"}, exp_b, m_lsu_msg.st_data);
				check_val({tag, " rd"}, ctrl[20:16], m_lsu_rd_id);
				check_val({tag, " id"}, exp_id, m_lsu_inst_id);
			end
			default: begin
				check_val({tag, " res_hi"}, ctrl[4], m_mul_msg.res_hi);
				check_val({tag, " op_a"}, {ctrl[8], exp_a}, m_mul_msg.op_a);
				check_val({tag, " op_b"}, {ctrl[9], exp_b}, m_mul_msg.op_b);
				check_val({tag, " pad"}, 1'b0, m_mul_msg.pad);
				check_val({tag, " rd"}, ctrl[20:16], m_mul_rd_id);
				check_val({tag, " id"}, exp_id, m_mul_inst_id);
			end
		endcase
	endtask

	initial begin
		int rec;
		int send_idx;
		int disp_cnt;
		logic [31:0] kind;
		logic [31:0] ctrl;
		logic [31:0] pre_rd;
		logic if_fire;
		logic wb_pend;
		logic [4:0] wb_rd;
		logic [31:0] wb_data;
		rst = 1'b1;
		flush_req = 1'b0;
		s_if_data = '0;
		s_if_valid = 1'b0;
		m_alu_ready = 1'b0;
		m_lsu_ready = 1'b0;
		m_mul_ready = 1'b0;
		wb = '0;
		trace_loaded = 1'b0;
		seed = 32'hc17ca727;
		n_pre = 0;
		n_inst = 0;
		$readmemh("dcd_trace.txt", trace_mem);
		rec = 0;
		kind = trace_mem[0];
		while (kind !== 32'hf) begin
			if (kind === 32'h0 && n_inst == 0) begin
				n_pre++;
			end else if (kind === 32'h1) begin
				n_inst++;
			end else begin
				stop_run("trace file holds a bad record or misses its end record");
			end
			rec++;
			if ((rec + 1) * REC_WORDS > MAX_WORDS) stop_run("trace file has no end record");
			kind = trace_mem[rec * REC_WORDS];
		end
		if (n_inst == 0) stop_run("trace file holds no instructions");
		trace_loaded = 1'b1;

		repeat (8) @(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < n_pre; i++) begin // register preload through writeback
			@(negedge clk);
			pre_rd = rec_word(i, 1);
			wb.valid = 1'b1;
			wb.rd = pre_rd[4:0];
			wb.data = rec_word(i, 2);
		end
		@(negedge clk);
		wb = '0;

		send_idx = 0;
		disp_cnt = 0;
		if_fire = 1'b0;
		wb_pend = 1'b0;
		while (disp_cnt < n_inst) begin
			@(negedge clk);
			// transfers decided on the last falling edge took place at the rising edge
			if (if_fire) begin
				send_idx++;
				s_if_valid = 1'b0;
			end
			wb = '0;
			if (wb_pend) begin
				wb.valid = 1'b1;
				wb.rd = wb_rd;
				wb.data = wb_data;
				wb_pend = 1'b0;
			end
			if (!s_if_valid && send_idx < n_inst && ($random(seed) & 3) != 0) begin
				s_if_valid = 1'b1;
				s_if_data = {rec_word(n_pre + send_idx, 2), rec_word(n_pre + send_idx, 1)};
			end
			m_alu_ready = ($random(seed) & 3) != 0;
			m_lsu_ready = ($random(seed) & 3) != 0;
			m_mul_ready = ($random(seed) & 3) != 0;
			// outputs are registered, so they hold until the next rising edge
			if_fire = s_if_valid && s_if_ready;
			if ($countones({m_alu_valid, m_lsu_valid, m_mul_valid}) > 1) begin
				stop_run("more than one unit port is valid at the same time");
			end
			if ((m_alu_valid && m_alu_ready) || (m_lsu_valid && m_lsu_ready) ||
				(m_mul_valid && m_mul_ready)) begin
				check_dispatch(n_pre + disp_cnt, disp_cnt);
				ctrl = rec_word(n_pre + disp_cnt, 3);
				if (ctrl[20:16] != 5'd0) begin // unit result goes back next cycle
					wb_pend = 1'b1;
					wb_rd = ctrl[20:16];
					wb_data = rec_word(n_pre + disp_cnt, 6);
				end
				disp_cnt++;
			end
		end

		@(negedge clk);
		s_if_valid = 1'b0;
		m_alu_ready = 1'b1;
		m_lsu_ready = 1'b1;
		m_mul_ready = 1'b1;
		wb = '0;
		if (wb_pend) begin
			wb.valid = 1'b1;
			wb.rd = wb_rd;
			wb.data = wb_data;
		end
		@(negedge clk);
		wb = '0;
		repeat (20) begin // a duplicate would show up here
			@(negedge clk);
			if (m_alu_valid || m_lsu_valid || m_mul_valid) begin
				stop_run("a unit port is valid after the last trace instruction");
			end
		end
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		wait (trace_loaded === 1'b1);
		repeat (200 * (n_pre + n_inst)) @(posedge clk);
		$display("timeout, the trace did not finish in time");
		$display("FAIL: see errors above");
		$fatal(1);
	end

endmodule
